//--- dataram_arb_defines.svh
`ifndef DATARAM_ARB_DEFINES_SVH
`define DATARAM_ARB_DEFINES_SVH

`define DA_NUM_RAMS      8
`define DA_NUM_CHANNELS  2
`define DA_RAM_ID_W      3
`define DA_TIMER_W       16     // Timer depth in cycles

`define DA_NUM_RD_SRC    3
`define DA_NUM_WR_SRC    3

// Read block delay per RAM group
`define DA_RD_BLOCK0     1
`define DA_RD_BLOCK1     2
`define DA_RD_BLOCK2     3
`define DA_RD_BLOCK3     4

`define DA_WR_BLOCK0     8      // Write block delay, group 0
`define DA_WR_BLOCK1     7
`define DA_WR_BLOCK2     6
`define DA_WR_BLOCK3     5

`define DA_WR_CMD_WEST   2
`define DA_WR_CMD_EAST   3
`define DA_WR_CMD_LF     6      // Linefill lands last

`endif

//--- dataram_arb_pkg.sv
`default_nettype none

`include "dataram_arb_defines.svh"

package dataram_arb_pkg;

    typedef enum logic [1:0] {
        RD_WEST  = 2'd0,
        RD_EAST  = 2'd1,
        RD_EVICT = 2'd2
    } rd_src_e;

    typedef enum logic [1:0] {
        WR_WEST     = 2'd0,
        WR_EAST     = 2'd1,
        WR_LINEFILL = 2'd2
    } wr_src_e;

    typedef logic [`DA_RAM_ID_W-1:0] ram_id_t;
    typedef logic [`DA_TIMER_W-1:0]  timer_t;

    // Cycles from write grant to channel use
    function automatic int unsigned wr_cmd_delay(wr_src_e src);
        case (src)
            WR_WEST: return `DA_WR_CMD_WEST;
            WR_EAST: return `DA_WR_CMD_EAST;
            default: return `DA_WR_CMD_LF;
        endcase
    endfunction

    function automatic int unsigned wr_block_delay(logic [1:0] grp);
        case (grp)
            2'd0:    return `DA_WR_BLOCK0;
            2'd1:    return `DA_WR_BLOCK1;
            2'd2:    return `DA_WR_BLOCK2;
            default: return `DA_WR_BLOCK3;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- slot_timers.sv
`default_nettype none

`include "dataram_arb_defines.svh"

module slot_timers
    import dataram_arb_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    wr_fire,
    input  wr_src_e wr_src,
    input  ram_id_t wr_ram_id,
    output timer_t  chan_busy [`DA_NUM_CHANNELS],
    output timer_t  ram_busy  [`DA_NUM_RAMS]
);

    int unsigned cmd_dly;
    int unsigned ram_dly;
    timer_t      chan_next [`DA_NUM_CHANNELS];
    timer_t      ram_next  [`DA_NUM_RAMS];

    assign cmd_dly = wr_cmd_delay(wr_src);
    assign ram_dly = cmd_dly + wr_block_delay(wr_ram_id[2:1]);  // Grant to RAM busy

    always_comb begin
        for (int c = 0; c < `DA_NUM_CHANNELS; c++) begin
            chan_next[c] = chan_busy[c] >> 1;
        end
        for (int r = 0; r < `DA_NUM_RAMS; r++) begin
            ram_next[r] = ram_busy[r] >> 1;
        end
        // The new bit lands one below its slot since the bank shifts at the same edge
        if (wr_fire) begin
            chan_next[wr_ram_id[0]][cmd_dly-1] = 1'b1;
            ram_next[wr_ram_id][ram_dly-1]     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int c = 0; c < `DA_NUM_CHANNELS; c++) begin
                chan_busy[c] <= '0;
            end
            for (int r = 0; r < `DA_NUM_RAMS; r++) begin
                ram_busy[r] <= '0;
            end
        end else begin
            chan_busy <= chan_next;
            ram_busy  <= ram_next;
        end
    end

    // Hazard mask upstream must keep a granted write off occupied slots
    a_chan_free: assert property (@(posedge clk) disable iff (!rst_n)
        wr_fire |-> !chan_busy[wr_ram_id[0]][cmd_dly])
        else $error("write granted onto a busy channel slot");

    a_ram_free: assert property (@(posedge clk) disable iff (!rst_n)
        wr_fire |-> !ram_busy[wr_ram_id][ram_dly])
        else $error("write granted onto a busy RAM slot");

endmodule

`default_nettype wire

//--- hazard_mask.sv
`default_nettype none

`include "dataram_arb_defines.svh"

module hazard_mask
    import dataram_arb_pkg::*;
(
    input  logic    rd_vld     [`DA_NUM_RD_SRC],
    input  ram_id_t rd_ram_id  [`DA_NUM_RD_SRC],
    input  logic    wr_vld     [`DA_NUM_WR_SRC],
    input  ram_id_t wr_ram_id  [`DA_NUM_WR_SRC],
    input  timer_t  chan_busy  [`DA_NUM_CHANNELS],
    input  timer_t  ram_busy   [`DA_NUM_RAMS],
    output logic    rd_allowed [`DA_NUM_RD_SRC],
    output logic    wr_allowed [`DA_NUM_WR_SRC]
);

    function automatic int unsigned rd_block_delay(logic [1:0] grp);
        case (grp)
            2'd0:    return `DA_RD_BLOCK0;
            2'd1:    return `DA_RD_BLOCK1;
            2'd2:    return `DA_RD_BLOCK2;
            default: return `DA_RD_BLOCK3;
        endcase
    endfunction

    // Reads take the channel next cycle, the RAM after the group delay
    for (genvar i = 0; i < `DA_NUM_RD_SRC; i++) begin : g_rd
        logic chan_ok;
        logic ram_ok;

        assign chan_ok = !chan_busy[rd_ram_id[i][0]][0];
        assign ram_ok  = !ram_busy[rd_ram_id[i]][rd_block_delay(rd_ram_id[i][2:1])];

        assign rd_allowed[i] = rd_vld[i] && chan_ok && ram_ok;
    end

    for (genvar i = 0; i < `DA_NUM_WR_SRC; i++) begin : g_wr
        localparam int unsigned CMD_DLY = wr_cmd_delay(wr_src_e'(i));  // Fixed per source

        logic        chan_ok;
        logic        ram_ok;
        int unsigned ram_slot;

        assign ram_slot = CMD_DLY + wr_block_delay(wr_ram_id[i][2:1]);
        assign chan_ok  = !chan_busy[wr_ram_id[i][0]][CMD_DLY];
        assign ram_ok   = !ram_busy[wr_ram_id[i]][ram_slot];

        assign wr_allowed[i] = wr_vld[i] && chan_ok && ram_ok;
    end

endmodule

`default_nettype wire

//--- rr_grant.sv
`default_nettype none

module rr_grant
    import dataram_arb_pkg::*;
#(
    parameter int unsigned NUM_SRC = 3
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req        [NUM_SRC],
    input  ram_id_t    req_ram_id [NUM_SRC],
    input  logic       arb_rdy,
    output logic       gnt        [NUM_SRC],
    output logic       out_vld,
    output logic [1:0] out_src,
    output ram_id_t    out_ram_id
);

    logic [1:0]         ptr;  // Highest priority source
    logic [1:0]         win;
    logic               found;
    logic               fire;
    logic [NUM_SRC-1:0] req_vec;
    logic [NUM_SRC-1:0] gnt_vec;

    always_comb begin
        found = 1'b0;
        win   = 2'd0;
        for (int off = 0; off < NUM_SRC; off++) begin
            if (!found && req[(int'(ptr) + off) % NUM_SRC]) begin
                found = 1'b1;
                win   = 2'((int'(ptr) + off) % NUM_SRC);
            end
        end
    end

    assign fire = found && arb_rdy && rst_n;  // Nothing leaves under back-pressure

    for (genvar i = 0; i < NUM_SRC; i++) begin : g_src
        assign req_vec[i] = req[i];
        assign gnt_vec[i] = fire && (win == 2'(i));
        assign gnt[i]     = gnt_vec[i];
    end

    assign out_vld    = fire;
    assign out_src    = win;
    assign out_ram_id = req_ram_id[win];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr <= 2'd0;
        end else if (fire) begin
            ptr <= (int'(win) == NUM_SRC - 1) ? 2'd0 : win + 2'd1;
        end
    end

    a_gnt_legal: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(gnt_vec) && ((gnt_vec & ~req_vec) == '0))
        else $error("illegal grant vector");

endmodule

`default_nettype wire

//--- dataram_arb_top.sv
`default_nettype none

`include "dataram_arb_defines.svh"

module dataram_arb_top
    import dataram_arb_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,

    input  logic    rd_vld    [`DA_NUM_RD_SRC],
    input  ram_id_t rd_ram_id [`DA_NUM_RD_SRC],
    output logic    rd_rdy    [`DA_NUM_RD_SRC],
    input  logic    wr_vld    [`DA_NUM_WR_SRC],
    input  ram_id_t wr_ram_id [`DA_NUM_WR_SRC],
    output logic    wr_rdy    [`DA_NUM_WR_SRC],

    input  logic    arb_rdy,  // Downstream back-pressure
    output logic    out_rd_vld,
    output rd_src_e out_rd_src,
    output ram_id_t out_rd_ram_id,
    output logic    out_wr_vld,
    output wr_src_e out_wr_src,
    output ram_id_t out_wr_ram_id
);

    logic       rd_allowed [`DA_NUM_RD_SRC];
    logic       wr_allowed [`DA_NUM_WR_SRC];
    timer_t     chan_busy  [`DA_NUM_CHANNELS];
    timer_t     ram_busy   [`DA_NUM_RAMS];
    logic [1:0] rd_idx;
    logic [1:0] wr_idx;

    assign out_rd_src = rd_src_e'(rd_idx);
    assign out_wr_src = wr_src_e'(wr_idx);

    hazard_mask u_hazard_mask (
        .rd_vld     (rd_vld),
        .rd_ram_id  (rd_ram_id),
        .wr_vld     (wr_vld),
        .wr_ram_id  (wr_ram_id),
        .chan_busy  (chan_busy),
        .ram_busy   (ram_busy),
        .rd_allowed (rd_allowed),
        .wr_allowed (wr_allowed)
    );

    rr_grant #(
        .NUM_SRC (`DA_NUM_RD_SRC)
    ) u_rd_grant (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (rd_allowed),
        .req_ram_id (rd_ram_id),
        .arb_rdy    (arb_rdy),
        .gnt        (rd_rdy),
        .out_vld    (out_rd_vld),
        .out_src    (rd_idx),
        .out_ram_id (out_rd_ram_id)
    );

    rr_grant #(
        .NUM_SRC (`DA_NUM_WR_SRC)
    ) u_wr_grant (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (wr_allowed),
        .req_ram_id (wr_ram_id),
        .arb_rdy    (arb_rdy),
        .gnt        (wr_rdy),
        .out_vld    (out_wr_vld),
        .out_src    (wr_idx),
        .out_ram_id (out_wr_ram_id)
    );

    // Only the write winner books slots
    slot_timers u_slot_timers (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_fire    (out_wr_vld),
        .wr_src     (out_wr_src),
        .wr_ram_id  (out_wr_ram_id),
        .chan_busy  (chan_busy),
        .ram_busy   (ram_busy)
    );

endmodule

`default_nettype wire

//--- tb_dataram_arb.sv
`default_nettype none

`include "dataram_arb_defines.svh"

module tb_dataram_arb
    import dataram_arb_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES    = 16;
    localparam int NUM_RESETS      = 5;   // Every directed test starts from reset
    localparam int DIRECTED_CYCLES = 40;
    localparam int RANDOM_CYCLES   = 300;
    localparam int WATCHDOG_CYCLES = 1000 + NUM_RESETS * RESET_CYCLES + DIRECTED_CYCLES
                                     + RANDOM_CYCLES;
    localparam int RD_BLK [4] = '{`DA_RD_BLOCK0, `DA_RD_BLOCK1, `DA_RD_BLOCK2, `DA_RD_BLOCK3};
    localparam int WR_BLK [4] = '{`DA_WR_BLOCK0, `DA_WR_BLOCK1, `DA_WR_BLOCK2, `DA_WR_BLOCK3};
    localparam int WR_CMD [3] = '{`DA_WR_CMD_WEST, `DA_WR_CMD_EAST, `DA_WR_CMD_LF};

    logic    clk = 1'b0;
    logic    rst_n;
    logic    rd_vld    [`DA_NUM_RD_SRC];
    ram_id_t rd_ram_id [`DA_NUM_RD_SRC];
    logic    rd_rdy    [`DA_NUM_RD_SRC];
    logic    wr_vld    [`DA_NUM_WR_SRC];
    ram_id_t wr_ram_id [`DA_NUM_WR_SRC];
    logic    wr_rdy    [`DA_NUM_WR_SRC];
    logic    arb_rdy;
    logic    out_rd_vld;
    rd_src_e out_rd_src;
    ram_id_t out_rd_ram_id;
    logic    out_wr_vld;
    wr_src_e out_wr_src;
    ram_id_t out_wr_ram_id;

    timer_t      m_chan [`DA_NUM_CHANNELS] = '{default: '0};  // Model timers, current cycle
    timer_t      m_ram  [`DA_NUM_RAMS]     = '{default: '0};
    timer_t      n_chan [`DA_NUM_CHANNELS] = '{default: '0};
    timer_t      n_ram  [`DA_NUM_RAMS]     = '{default: '0};
    int          m_rd_ptr = 0;
    int          m_wr_ptr = 0;
    int          n_rd_ptr = 0;
    int          n_wr_ptr = 0;
    logic        seen_rd [`DA_NUM_RD_SRC] = '{default: 1'b0};  // DUT grants, last cycle
    logic        seen_wr [`DA_NUM_WR_SRC] = '{default: 1'b0};
    logic [15:0] lfsr = 16'd29;

    dataram_arb_top u_dataram_arb_top (.*);

    always #5 clk = ~clk;

    function automatic int unsigned lfsr_bits(int n);
        int unsigned val = 0;
        for (int b = 0; b < n; b++) begin
            val  = (val << 1) | lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic int first_req(logic [2:0] ok, int ptr);
        for (int off = 0; off < 3; off++) begin
            if (ok[(ptr + off) % 3]) begin
                return (ptr + off) % 3;
            end
        end
        return -1;
    endfunction

    function automatic logic any_grant();
        logic any = 1'b0;
        for (int i = 0; i < 3; i++) begin
            any = any | seen_rd[i] | seen_wr[i];
        end
        return any;
    endfunction

    task automatic check_value(string what, logic [7:0] got, logic [7:0] exp);
        assert (got === exp) else begin
            $display("error: time %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // Expected outputs from the current model state, then the model's next state
    task automatic model_check();
        logic [2:0] rd_ok;
        logic [2:0] wr_ok;
        int         rw;
        int         ww;
        for (int i = 0; i < 3; i++) begin
            rd_ok[i] = rd_vld[i] && !m_chan[rd_ram_id[i][0]][0]
                       && !m_ram[rd_ram_id[i]][RD_BLK[rd_ram_id[i][2:1]]];
            wr_ok[i] = wr_vld[i] && !m_chan[wr_ram_id[i][0]][WR_CMD[i]]
                       && !m_ram[wr_ram_id[i]][WR_CMD[i] + WR_BLK[wr_ram_id[i][2:1]]];
        end
        rw = (arb_rdy && rst_n) ? first_req(rd_ok, m_rd_ptr) : -1;
        ww = (arb_rdy && rst_n) ? first_req(wr_ok, m_wr_ptr) : -1;
        for (int i = 0; i < 3; i++) begin
            check_value($sformatf("rd_rdy[%0d]", i), rd_rdy[i], rw == i);
            check_value($sformatf("wr_rdy[%0d]", i), wr_rdy[i], ww == i);
            seen_rd[i] = rd_rdy[i];
            seen_wr[i] = wr_rdy[i];
        end
        check_value("out_rd_vld", out_rd_vld, rw >= 0);
        check_value("out_wr_vld", out_wr_vld, ww >= 0);
        if (rw >= 0) begin
            check_value("out_rd_src", out_rd_src, 8'(rw));
            check_value("out_rd_ram_id", out_rd_ram_id, rd_ram_id[rw]);
        end
        if (ww >= 0) begin
            check_value("out_wr_src", out_wr_src, 8'(ww));
            check_value("out_wr_ram_id", out_wr_ram_id, wr_ram_id[ww]);
        end
        for (int c = 0; c < `DA_NUM_CHANNELS; c++) begin
            n_chan[c] = rst_n ? (m_chan[c] >> 1) : '0;
        end
        for (int r = 0; r < `DA_NUM_RAMS; r++) begin
            n_ram[r] = rst_n ? (m_ram[r] >> 1) : '0;
        end
        if (ww >= 0) begin
            n_chan[wr_ram_id[ww][0]][WR_CMD[ww] - 1] = 1'b1;
            n_ram[wr_ram_id[ww]][WR_CMD[ww] + WR_BLK[wr_ram_id[ww][2:1]] - 1] = 1'b1;
        end
        n_rd_ptr = !rst_n ? 0 : (rw >= 0) ? (rw + 1) % 3 : m_rd_ptr;
        n_wr_ptr = !rst_n ? 0 : (ww >= 0) ? (ww + 1) % 3 : m_wr_ptr;
    endtask

    always @(negedge clk) model_check();

    always @(posedge clk) begin
        m_chan   = n_chan;
        m_ram    = n_ram;
        m_rd_ptr = n_rd_ptr;
        m_wr_ptr = n_wr_ptr;
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic clear_inputs();
        for (int i = 0; i < 3; i++) begin
            rd_vld[i]    = 1'b0;
            rd_ram_id[i] = '0;
            wr_vld[i]    = 1'b0;
            wr_ram_id[i] = '0;
        end
        arb_rdy = 1'b1;
    endtask

    // All requests stay up while reset holds the arbiter quiet
    task automatic apply_reset();
        rst_n = 1'b0;
        for (int i = 0; i < 3; i++) begin
            rd_vld[i]    = 1'b1;
            rd_ram_id[i] = ram_id_t'(i + 3);
            wr_vld[i]    = 1'b1;
            wr_ram_id[i] = ram_id_t'(i);
        end
        repeat (RESET_CYCLES) begin
            next_cycle();
            check_value("grant during reset", any_grant(), 1'b0);
        end
        clear_inputs();
        rst_n = 1'b1;
    endtask

    task automatic write_then_read();
        apply_reset();
        wr_vld[WR_WEST]    = 1'b1;
        wr_ram_id[WR_WEST] = 3'd2;
        next_cycle();
        check_value("west write grant", seen_wr[WR_WEST], 1'b1);
        wr_vld[WR_WEST] = 1'b0;
        repeat (6) next_cycle();
        // Slot 8 booking has shifted down to the group 1 read delay
        check_value("RAM 2 read slot in model", m_ram[2][RD_BLK[1]], 1'b1);
        rd_vld[RD_EAST]    = 1'b1;
        rd_ram_id[RD_EAST] = 3'd2;
        next_cycle();
        check_value("east read refused", seen_rd[RD_EAST], 1'b0);
        next_cycle();
        check_value("east read granted", seen_rd[RD_EAST], 1'b1);
        clear_inputs();
    endtask

    task automatic read_rotation();
        apply_reset();
        rd_ram_id[RD_WEST]     = 3'd0;
        rd_ram_id[RD_EAST]     = 3'd3;
        rd_ram_id[RD_EVICT]    = 3'd4;
        rd_vld                 = '{default: 1'b1};
        wr_vld[WR_LINEFILL]    = 1'b1;
        wr_ram_id[WR_LINEFILL] = 3'd5;
        for (int n = 0; n < 4; n++) begin
            next_cycle();
            check_value($sformatf("read order step %0d", n), seen_rd[n % 3], 1'b1);
            if (n == 0) begin
                check_value("write beside read", seen_wr[WR_LINEFILL], 1'b1);
                wr_vld[WR_LINEFILL] = 1'b0;
            end
        end
        clear_inputs();
    endtask

    task automatic back_pressure();
        apply_reset();
        rd_vld[RD_WEST]        = 1'b1;
        rd_ram_id[RD_WEST]     = 3'd2;
        wr_vld[WR_LINEFILL]    = 1'b1;
        wr_ram_id[WR_LINEFILL] = 3'd0;  // RAM 0 booked at slot 13
        next_cycle();
        check_value("west read grant", seen_rd[RD_WEST], 1'b1);
        check_value("linefill grant", seen_wr[WR_LINEFILL], 1'b1);
        wr_vld[WR_LINEFILL] = 1'b0;
        rd_ram_id[RD_WEST]  = 3'd0;
        rd_vld[RD_EAST]     = 1'b1;
        rd_ram_id[RD_EAST]  = 3'd3;
        rd_vld[RD_EVICT]    = 1'b1;
        rd_ram_id[RD_EVICT] = 3'd4;
        arb_rdy             = 1'b0;
        repeat (10) begin
            next_cycle();
            check_value("grant under back-pressure", any_grant(), 1'b0);
        end
        arb_rdy = 1'b1;
        next_cycle();
        check_value("east first after release", seen_rd[RD_EAST], 1'b1);
        rd_vld[RD_EAST] = 1'b0;
        next_cycle();
        check_value("evict next", seen_rd[RD_EVICT], 1'b1);
        rd_vld[RD_EVICT] = 1'b0;
        next_cycle();
        check_value("west refused on shifted booking", seen_rd[RD_WEST], 1'b0);
        next_cycle();
        check_value("west granted", seen_rd[RD_WEST], 1'b1);
        clear_inputs();
    endtask

    task automatic channel_clash();
        apply_reset();
        wr_vld[WR_EAST]    = 1'b1;
        wr_ram_id[WR_EAST] = 3'd1;
        next_cycle();
        check_value("east write grant", seen_wr[WR_EAST], 1'b1);
        wr_vld[WR_EAST]    = 1'b0;
        wr_vld[WR_WEST]    = 1'b1;
        wr_ram_id[WR_WEST] = 3'd3;  // Same channel, one cycle later
        next_cycle();
        check_value("west write refused", seen_wr[WR_WEST], 1'b0);
        next_cycle();
        check_value("west write granted", seen_wr[WR_WEST], 1'b1);
        wr_vld[WR_WEST]        = 1'b0;
        wr_vld[WR_LINEFILL]    = 1'b1;
        wr_ram_id[WR_LINEFILL] = 3'd6;
        next_cycle();
        check_value("linefill grant", seen_wr[WR_LINEFILL], 1'b1);
        wr_vld[WR_LINEFILL] = 1'b0;
        repeat (3) next_cycle();
        wr_vld[WR_WEST]    = 1'b1;
        wr_ram_id[WR_WEST] = 3'd6;
        next_cycle();
        check_value("west refused behind linefill", seen_wr[WR_WEST], 1'b0);
        next_cycle();
        check_value("west granted after linefill", seen_wr[WR_WEST], 1'b1);
        clear_inputs();
    endtask

    // Requests stay up until granted, new ones appear at random
    task automatic random_traffic();
        apply_reset();
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            for (int i = 0; i < 3; i++) begin
                if (seen_rd[i]) rd_vld[i] = 1'b0;
                if (!rd_vld[i]) begin
                    rd_vld[i]    = lfsr_bits(1) != 0;
                    rd_ram_id[i] = ram_id_t'(lfsr_bits(3));
                end
                if (seen_wr[i]) wr_vld[i] = 1'b0;
                if (!wr_vld[i]) begin
                    wr_vld[i]    = lfsr_bits(1) != 0;
                    wr_ram_id[i] = ram_id_t'(lfsr_bits(3));
                end
            end
            arb_rdy = lfsr_bits(2) != 0;
            next_cycle();
        end
        clear_inputs();
    endtask

    initial begin
        rst_n = 1'b0;
        clear_inputs();
        next_cycle();
        write_then_read();
        read_rotation();
        back_pressure();
        channel_clash();
        random_traffic();
        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- dataram_arb_top.f
+incdir+.
dataram_arb_pkg.sv
slot_timers.sv
hazard_mask.sv
rr_grant.sv
dataram_arb_top.sv
tb_dataram_arb.sv

//--- Makefile
TB_TOP := tb_dataram_arb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module dataram_arb_top -f dataram_arb_top.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TB_TOP) \
		-f dataram_arb_top.f -o sim_tb
	@out=$$(./obj_dir/sim_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTBENCH PASSED$$"

clean:
	rm -rf obj_dir
